// File: files.f
+incdir+hdl
hdl/audio_pkg.sv
hdl/sample_stream_if.sv
hdl/source_mixer.sv
hdl/sample_fifo.sv
hdl/range_compressor.sv
hdl/audio_mix_top.sv
testbench/tb_audio_mix.sv

// File: Bender.yml
package:
  name: audio_mix

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/audio_pkg.sv
      - hdl/sample_stream_if.sv
      - hdl/source_mixer.sv
      - hdl/sample_fifo.sv
      - hdl/range_compressor.sv
      - hdl/audio_mix_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_audio_mix.sv

// File: testbench/tb_audio_mix.sv
////////////////////////////////////////////////////////////
// Testbench for the audio mixing path
// A reference model queues expected stereo pairs per input
// transfer, and concurrent assertions check every output
////////////////////////////////////////////////////////////

`include "audio_cfg.svh"

module tb_audio_mix
	import audio_pkg::*;
();

	localparam logic [31:0] SEED = 32'hd0628f71;
	localparam int HALF_PERIOD     = 10;
	localparam int RESET_CYCLES    = 5;
	localparam int PIPE_LATENCY    = 5;
	// Mixer stages, FIFO entries and the compressor register
	localparam int MAX_BUFFERED    = 3 + `FIFO_DEPTH + 1;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 400;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST + 200;

	logic    clk_sys;
	logic    reset;
	logic    in_valid;
	logic    in_ready;
	sample_t cdda_left;
	sample_t cdda_right;
	sample_t adpcm;
	sample_t psg_left;
	sample_t psg_right;
	boost_e  boost;
	logic    out_valid;
	logic    out_ready;
	sample_t audio_left;
	sample_t audio_right;

	// Reference model state
	stereo_t exp_q[$];
	int      stamp_q[$];
	stereo_t exp_head;
	int      head_stamp;
	int      exp_count;
	int      cycle;

	// Test phase flags, driven on the falling edge
	logic    lat_check;
	logic    stall_mode;
	int      stall_cycles;
	int      stall_accepts;

	audio_mix_top audio_mix_top_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.cdda_left   (cdda_left),
		.cdda_right  (cdda_right),
		.adpcm       (adpcm),
		.psg_left    (psg_left),
		.psg_right   (psg_right),
		.boost       (boost),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.audio_left  (audio_left),
		.audio_right (audio_right)
	);

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////

	// Attenuate, sum and scale one side, top 16 of the 18-bit result
	function automatic int mixed_side(int cd, int psg, int voice);
		int psg_lvl;
		int voice_lvl;
		int sum;
		int scaled;
		psg_lvl   = (psg >>> 1) + (psg >>> 2) + (psg >>> 4);
		voice_lvl = (voice >>> 1) + (voice >>> 2) + (voice >>> 3);
		sum       = cd + psg_lvl + voice_lvl;
		scaled    = sum + (sum >>> 2);
		return scaled >>> 2;
	endfunction

	function automatic int knee_curve(int s, int knee, int gain, int div);
		int mag;
		int res;
		mag = (s < 0) ? -s : s;
		if (mag < knee)
			res = mag * gain;
		else
			res = (mag - knee) / div + knee * gain;
		res = res & 32'h0000_ffff;
		return (s < 0) ? -res : res;
	endfunction

	function automatic stereo_t expected_pair(sample_t cl, sample_t cr, sample_t ad,
			sample_t pl, sample_t pr, boost_e mode);
		int      l;
		int      r;
		stereo_t pair;
		l = mixed_side(cl, pl, ad);
		r = mixed_side(cr, pr, ad);
		case (mode)
			boost_off: begin
			end
			boost_2x: begin
				l = knee_curve(l, `COMP_X1, `COMP_A1, `COMP_F1);
				r = knee_curve(r, `COMP_X1, `COMP_A1, `COMP_F1);
			end
			default: begin
				l = knee_curve(l, `COMP_X2, `COMP_A2, `COMP_F2);
				r = knee_curve(r, `COMP_X2, `COMP_A2, `COMP_F2);
			end
		endcase
		pair.left  = sample_t'(l);
		pair.right = sample_t'(r);
		return pair;
	endfunction

	// Queue update on each transfer, stamped with the acceptance cycle
	always @(posedge clk_sys) begin
		if (reset) begin
			exp_q.delete();
			stamp_q.delete();
			cycle         = 0;
			stall_cycles  = 0;
			stall_accepts = 0;
		end else begin
			if (in_valid && in_ready) begin
				exp_q.push_back(expected_pair(cdda_left, cdda_right, adpcm,
					psg_left, psg_right, boost));
				stamp_q.push_back(cycle);
			end
			if (out_valid && out_ready && exp_q.size() > 0) begin
				void'(exp_q.pop_front());
				void'(stamp_q.pop_front());
			end
			if (stall_mode) begin
				stall_cycles = stall_cycles + 1;
				if (in_valid && in_ready)
					stall_accepts = stall_accepts + 1;
			end else begin
				stall_cycles  = 0;
				stall_accepts = 0;
			end
			cycle = cycle + 1;
		end
		exp_count = exp_q.size();
		if (exp_count > 0) begin
			exp_head   = exp_q[0];
			head_stamp = stamp_q[0];
		end
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////

	check_idle_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> (in_ready && !out_valid))
		else report_failure("in_ready low or out_valid high right after reset");

	check_output_data: assert property (@(posedge clk_sys) disable iff (reset)
		(out_valid && out_ready) |->
			(audio_left == exp_head.left && audio_right == exp_head.right))
		else report_failure($sformatf("Fail at %0t: output %0d/%0d, expected %0d/%0d",
			$time, $sampled(audio_left), $sampled(audio_right),
			$sampled(exp_head.left), $sampled(exp_head.right)));

	check_output_expected: assert property (@(posedge clk_sys) disable iff (reset)
		out_valid |-> (exp_count != 0))
		else report_failure("Output valid with no sample outstanding");

	check_latency: assert property (@(posedge clk_sys) disable iff (reset)
		(lat_check && out_valid && out_ready) |-> (cycle - head_stamp == PIPE_LATENCY))
		else report_failure($sformatf("Fail at %0t: latency %0d cycles, expected %0d",
			$time, $sampled(cycle) - $sampled(head_stamp), PIPE_LATENCY));

	check_stall_bound: assert property (@(posedge clk_sys) disable iff (reset)
		stall_mode |-> (stall_accepts <= MAX_BUFFERED))
		else report_failure("More samples accepted than the path can hold");

	check_stall_blocks: assert property (@(posedge clk_sys) disable iff (reset)
		(stall_mode && stall_cycles >= 12) |-> !in_ready)
		else report_failure("in_ready stayed high with the output stalled");

	check_ready_returns: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(stall_mode) |-> ##[1:2] in_ready)
		else report_failure("in_ready did not rise after the output stall ended");

	//////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send_set(input sample_t cl, input sample_t cr, input sample_t ad,
			input sample_t pl, input sample_t pr);
		cdda_left  = cl;
		cdda_right = cr;
		adpcm      = ad;
		psg_left   = pl;
		psg_right  = pr;
		in_valid   = 1'b1;
		while (!in_ready)
			@(negedge clk_sys);
		@(negedge clk_sys);
		in_valid = 1'b0;
	endtask

	task automatic send_random();
		send_set(sample_t'($urandom), sample_t'($urandom), sample_t'($urandom),
			sample_t'($urandom), sample_t'($urandom));
	endtask

	// Same level on every source, right tone channel at half
	task automatic send_level(input int v);
		send_set(sample_t'(v), sample_t'(v), sample_t'(v), sample_t'(v), sample_t'(v / 2));
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic drain();
		while (exp_count != 0 || out_valid)
			@(negedge clk_sys);
	endtask

	task automatic corner_levels();
		int levels[11] = '{0, 1, -1, 64, -64, 4000, -4000, 12000, -12000, 32767, -32768};
		foreach (levels[i])
			send_level(levels[i]);
	endtask

	// Uniform inputs scale by 215/256 through the mixer
	task automatic knee_sweep(input int knee);
		int center;
		center = knee * 256 / 215;
		for (int v = center - 40; v <= center + 40; v += 2) begin
			send_level(v);
			send_level(-v);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		reset      = 1'b1;
		in_valid   = 1'b0;
		cdda_left  = '0;
		cdda_right = '0;
		adpcm      = '0;
		psg_left   = '0;
		psg_right  = '0;
		boost      = boost_off;
		out_ready  = 1'b1;
		lat_check  = 1'b0;
		stall_mode = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// Idle after reset, nothing may come out
		idle(4);

		// Plain mixing at fixed latency
		lat_check = 1'b1;
		repeat (40) begin
			send_random();
			idle($urandom_range(0, 3));
		end
		drain();

		// 2x curve
		boost = boost_2x;
		corner_levels();
		knee_sweep(`COMP_X1);
		drain();

		// 4x curve, then the unnamed code
		boost = boost_4x;
		corner_levels();
		knee_sweep(`COMP_X2);
		drain();
		boost = boost_e'(2'd3);
		corner_levels();
		knee_sweep(`COMP_X2);
		drain();
		lat_check = 1'b0;

		// Random back-pressure
		boost = boost_2x;
		fork
			repeat (100) begin
				send_random();
				idle($urandom_range(0, 2));
			end
			repeat (250) begin
				@(negedge clk_sys);
				out_ready = ($urandom_range(0, 3) != 0);
			end
		join
		out_ready = 1'b1;
		drain();

		// Long output stall fills the whole path
		boost      = boost_off;
		out_ready  = 1'b0;
		stall_mode = 1'b1;
		fork
			repeat (12) send_random();
			begin
				idle(20);
				out_ready  = 1'b1;
				stall_mode = 1'b0;
			end
		join
		drain();
		idle(4);

		if (exp_count == 0 && !out_valid) begin
			$display("Verification passed");
			$finish;
		end else begin
			report_failure("Expected outputs still pending at the end of the run");
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		report_failure("Watchdog expired before the tests completed");
	end

endmodule

// File: hdl/audio_mix_top.sv
////////////////////////////////////////////////////////////
// Audio path top: mixer, sample FIFO and boost compressor
// Input and output streams use plain valid/ready ports
////////////////////////////////////////////////////////////

module audio_mix_top
	import audio_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,

	// Source sample set
	input  logic    in_valid,
	output logic    in_ready,
	input  sample_t cdda_left,
	input  sample_t cdda_right,
	input  sample_t adpcm,
	input  sample_t psg_left,
	input  sample_t psg_right,

	// Hold steady while samples are in flight
	input  boost_e  boost,

	// Stereo output
	output logic    out_valid,
	input  logic    out_ready,
	output sample_t audio_left,
	output sample_t audio_right
);

	sample_stream_if mix_stream ();
	sample_stream_if comp_stream ();

	source_mixer source_mixer_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.cdda_left  (cdda_left),
		.cdda_right (cdda_right),
		.adpcm      (adpcm),
		.psg_left   (psg_left),
		.psg_right  (psg_right),
		.mix_out    (mix_stream.source)
	);

	sample_fifo sample_fifo_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wr      (mix_stream.sink),
		.rd      (comp_stream.source)
	);

	range_compressor range_compressor_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.boost       (boost),
		.comp_in     (comp_stream.sink),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.audio_left  (audio_left),
		.audio_right (audio_right)
	);

endmodule

// File: hdl/range_compressor.sv
////////////////////////////////////////////////////////////
// Output boost with soft knee compression near full scale
// One output register, stream in and plain valid/ready out
////////////////////////////////////////////////////////////

`include "audio_cfg.svh"

module range_compressor
	import audio_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  boost_e  boost,
	sample_stream_if.sink comp_in,
	output logic    out_valid,
	input  logic    out_ready,
	output sample_t audio_left,
	output sample_t audio_right
);

	localparam int W = `AUDIO_W;

	logic    in_fire;
	stereo_t shaped;

	// Gain below the knee, compressed slope above it, sign restored
	function automatic sample_t soft_knee(sample_t s, int knee, int gain, int div);
		logic [W-1:0] mag;
		logic [W-1:0] res;
		mag = s[W-1] ? (~s + 1'b1) : s;
		if (mag < knee)
			res = W'(mag * gain);
		else
			res = W'(((mag - knee) / div) + (knee * gain));
		return s[W-1] ? sample_t'(~res + 1'b1) : sample_t'(res);
	endfunction

	// Register takes a new sample when empty or being read
	assign comp_in.ready = !out_valid || out_ready;
	assign in_fire       = comp_in.valid && comp_in.ready;

	always_comb begin
		case (boost)
			boost_off: begin
				shaped = comp_in.data;
			end
			boost_2x: begin
				shaped.left  = soft_knee(comp_in.data.left, `COMP_X1, `COMP_A1, `COMP_F1);
				shaped.right = soft_knee(comp_in.data.right, `COMP_X1, `COMP_A1, `COMP_F1);
			end
			// 4x, and the unnamed code 3
			default: begin
				shaped.left  = soft_knee(comp_in.data.left, `COMP_X2, `COMP_A2, `COMP_F2);
				shaped.right = soft_knee(comp_in.data.right, `COMP_X2, `COMP_A2, `COMP_F2);
			end
		endcase
	end

	//////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			out_valid <= 1'b0;
		else if (in_fire)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (in_fire) begin
			audio_left  <= shaped.left;
			audio_right <= shaped.right;
		end
	end

	// Held sample must not change until the consumer takes it
	assert property (@(posedge clk_sys) disable iff (reset)
		(out_valid && !out_ready) |=>
			(out_valid && $stable(audio_left) && $stable(audio_right)));

endmodule

// File: hdl/sample_fifo.sv
////////////////////////////////////////////////////////////
// Stereo sample FIFO between the mixer and the compressor
// Circular buffer, registered occupancy, no bypass path
////////////////////////////////////////////////////////////

`include "audio_cfg.svh"

module sample_fifo
	import audio_pkg::*;
#(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input  logic clk_sys,
	input  logic reset,
	sample_stream_if.sink   wr,
	sample_stream_if.source rd
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = AW + 1;

	stereo_t         mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [CW-1:0]   count;
	logic            wr_fire;
	logic            rd_fire;

	// Handshake flags come from the occupancy alone
	assign wr.ready = (count != CW'(DEPTH));
	assign rd.valid = (count != '0);
	assign rd.data  = mem[rd_ptr];

	assign wr_fire = wr.valid && wr.ready;
	assign rd_fire = rd.valid && rd.ready;

	//////////////////////////////////////////////////////////////
	// Pointers and count
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Depth is a power of two so pointers wrap by overflow
			if (wr_fire)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_fire)
				rd_ptr <= rd_ptr + 1'b1;

			case ({wr_fire, rd_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk_sys) begin
		if (wr_fire)
			mem[wr_ptr] <= wr.data;
	end

	//////////////////////////////////////////////////////////////
	// Occupancy checks
	//////////////////////////////////////////////////////////////

	assert property (@(posedge clk_sys) disable iff (reset)
		count <= CW'(DEPTH));

	// An empty buffer can only gain one entry, never wrap to the top
	assert property (@(posedge clk_sys) disable iff (reset)
		(count == '0) |=> (count <= CW'(1)));

endmodule

// File: hdl/source_mixer.sv
////////////////////////////////////////////////////////////
// Attenuates CD, ADPCM and tone sources and sums them into a
// stereo pair. Three register stages that advance together
////////////////////////////////////////////////////////////

`include "audio_cfg.svh"

module source_mixer
	import audio_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    in_valid,
	output logic    in_ready,
	input  sample_t cdda_left,
	input  sample_t cdda_right,
	input  sample_t adpcm,
	input  sample_t psg_left,
	input  sample_t psg_right,
	sample_stream_if.source mix_out
);

	logic    advance;
	logic    s1_valid, s2_valid, s3_valid;
	sample_t s1_cdda_l, s1_cdda_r;
	sample_t s1_psg_l, s1_psg_r, s1_adpcm;
	mix_t    s2_sum_l, s2_sum_r;
	stereo_t s3_data;

	// Tone level is 1/2 + 1/4 + 1/16 of the input
	function automatic sample_t reduce_psg(sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 4);
	endfunction

	// ADPCM level is 1/2 + 1/4 + 1/8 of the input
	function automatic sample_t reduce_adpcm(sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 3);
	endfunction

	function automatic mix_t side_sum(sample_t cdda, sample_t psg, sample_t voice);
		return mix_t'(cdda) + mix_t'(psg) + mix_t'(voice);
	endfunction

	// Add a quarter and keep the top bits as the sample
	function automatic sample_t scale_top(mix_t sum);
		mix_t scaled;
		scaled = sum + (sum >>> 2);
		return scaled[`MIX_W-1 -: `AUDIO_W];
	endfunction

	// Whole pipe moves when the last stage drains or is empty
	assign advance  = !s3_valid || mix_out.ready;
	assign in_ready = advance;

	assign mix_out.valid = s3_valid;
	assign mix_out.data  = s3_data;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= in_valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
		end
	end

	//////////////////////////////////////////////////////////////
	// Sample stages
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (advance) begin
			s1_cdda_l <= cdda_left;
			s1_cdda_r <= cdda_right;
			s1_psg_l  <= reduce_psg(psg_left);
			s1_psg_r  <= reduce_psg(psg_right);
			s1_adpcm  <= reduce_adpcm(adpcm);

			// ADPCM is mono and feeds both sides
			s2_sum_l <= side_sum(s1_cdda_l, s1_psg_l, s1_adpcm);
			s2_sum_r <= side_sum(s1_cdda_r, s1_psg_r, s1_adpcm);

			s3_data.left  <= scale_top(s2_sum_l);
			s3_data.right <= scale_top(s2_sum_r);
		end
	end

	// A stalled pipe holds its last stage for the FIFO
	assert property (@(posedge clk_sys) disable iff (reset)
		!in_ready |=> (mix_out.valid && $stable(mix_out.data)));

endmodule

// File: hdl/sample_stream_if.sv
////////////////////////////////////////////////////////////
// Stereo sample stream with a valid/ready handshake
// A transfer happens on a clock edge with valid and ready high
////////////////////////////////////////////////////////////

interface sample_stream_if
	import audio_pkg::*;
();

	logic    valid;
	logic    ready;
	stereo_t data;

	// Producer side
	modport source (
		output valid,
		output data,
		input  ready
	);

	// Consumer side
	modport sink (
		input  valid,
		input  data,
		output ready
	);

endinterface

// File: hdl/audio_pkg.sv
////////////////////////////////////////////////////////////
// Shared types of the audio path
// Sample words, the stereo pair and the boost mode encoding
////////////////////////////////////////////////////////////

`include "audio_cfg.svh"

package audio_pkg;

	// One signed source or output sample
	typedef logic signed [`AUDIO_W-1:0] sample_t;

	// Intermediate mixing sum with headroom
	typedef logic signed [`MIX_W-1:0] mix_t;

	// Stereo pair as it travels on the stream
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// Boost selection
	// Code 3 is not named and is treated as 4x by the compressor
	typedef enum logic [1:0] {
		boost_off = 2'd0,
		boost_2x  = 2'd1,
		boost_4x  = 2'd2
	} boost_e;

endpackage

// File: hdl/audio_cfg.svh
////////////////////////////////////////////////////////////
// Width, buffer and compressor constants for the audio path
// Included by the package and by every module that needs a
// sample width, the FIFO depth or a knee setting
////////////////////////////////////////////////////////////

`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// Source and output sample width
`define AUDIO_W 16

// Mixing sum, two guard bits over a sample
`define MIX_W 18

// Stereo entries between mixer and compressor
`define FIFO_DEPTH 4

// 2x curve: gain below the knee, divisor above it
`define COMP_X1 14044
`define COMP_A1 2
`define COMP_F1 4

// 4x curve
`define COMP_X2 7399
`define COMP_A2 4
`define COMP_F2 8

`endif
